// ==== hdl/acc_pkg.sv ====
package acc_pkg;

	////////////////////
	// Widths
	////////////////////

	// Accumulator, operand and device byte
	localparam int data_w = 8;
	// Memory and PC address
	localparam int addr_w = 8;
	// Memory word, opcode in the top nibble
	localparam int word_w = 16;
	localparam int opc_w  = 4;

	////////////////////
	// Instruction set
	////////////////////

	// Encoding of instr[15:12], operand in instr[7:0]
	typedef enum logic [opc_w-1:0] {
		op_nop  = 4'h0,
		op_halt = 4'h1,
		op_ldi  = 4'h2,
		op_ldm  = 4'h3,
		op_stm  = 4'h4,
		op_add  = 4'h5,
		op_sub  = 4'h6,
		op_and  = 4'h7,
		op_xor  = 4'h8,
		op_shl  = 4'h9,
		op_shr  = 4'ha,
		op_jmp  = 4'hb,
		op_jz   = 4'hc,
		op_in   = 4'hd,
		op_out  = 4'he
	} opcode_t;

	// Execute stage sequencing
	typedef enum logic [2:0] {
		ex_idle,
		ex_exec,
		ex_mem_wait,
		ex_in_wait,
		ex_out_wait,
		ex_halt
	} exec_state_t;

	// Memory owner for one cycle
	typedef enum logic [1:0] {
		gnt_none,
		gnt_load,
		gnt_exec,
		gnt_fetch
	} grant_t;

endpackage

// ==== hdl/alu.sv ====
module alu import acc_pkg::*; (
	input  opcode_t           opcode,
	input  logic [data_w-1:0] a,
	input  logic [data_w-1:0] b,
	input  logic              flag_c_in,
	output logic [data_w-1:0] result,
	output logic              c_out,
	output logic              v_out,
	output logic              z_out
);

	localparam int msb = data_w - 1;

	// Carry-extended sum
	logic [data_w:0] sum;

	always_comb begin
		// Pass b through, carry kept, overflow clear
		sum    = '0;
		result = b;
		c_out  = flag_c_in;
		v_out  = 1'b0;
		case (opcode)
			op_add: begin
				sum    = {1'b0, a} + {1'b0, b};
				result = sum[msb:0];
				c_out  = sum[data_w];
				v_out  = (a[msb] == b[msb]) & (result[msb] != a[msb]);
			end
			op_sub: begin
				// a + ~b + 1, carry set when no borrow
				sum    = {1'b0, a} + {1'b0, ~b} + 1'b1;
				result = sum[msb:0];
				c_out  = sum[data_w];
				v_out  = (a[msb] != b[msb]) & (result[msb] != a[msb]);
			end
			op_and: result = a & b;
			op_xor: result = a ^ b;
			op_shl: begin
				result = {a[msb-1:0], 1'b0};
				c_out  = a[msb];
			end
			op_shr: begin
				result = {1'b0, a[msb:1]};
				c_out  = a[0];
			end
			default: ;
		endcase
	end

	assign z_out = (result == '0);

endmodule

// ==== hdl/mem_arbiter.sv ====
module mem_arbiter import acc_pkg::*; (
	input  logic              g_clk,
	input  logic              rst_n,
	// Program loader, writes only
	input  logic              load_req_valid,
	input  logic [addr_w-1:0] load_req_addr,
	input  logic [word_w-1:0] load_req_wdata,
	output logic              load_req_ready,
	// Execute stage data port
	input  logic              exec_req_valid,
	input  logic [addr_w-1:0] exec_req_addr,
	input  logic              exec_req_we,
	input  logic [data_w-1:0] exec_req_wdata,
	output logic              exec_req_ready,
	output logic              exec_rsp_valid,
	output logic [data_w-1:0] exec_rsp_data,
	// Fetch stage, reads only
	input  logic              fetch_req_valid,
	input  logic [addr_w-1:0] fetch_req_addr,
	output logic              fetch_req_ready,
	output logic              fetch_rsp_valid,
	output logic [word_w-1:0] fetch_rsp_data,
	// RAM side
	output logic              ram_en,
	output logic              ram_we,
	output logic [addr_w-1:0] ram_addr,
	output logic [word_w-1:0] ram_wdata,
	input  logic [word_w-1:0] ram_rdata
);

	grant_t gnt;
	// Owner of the read now in the RAM output register
	grant_t rd_gnt;

	// Fixed priority, loader first
	always_comb begin
		if (load_req_valid)       gnt = gnt_load;
		else if (exec_req_valid)  gnt = gnt_exec;
		else if (fetch_req_valid) gnt = gnt_fetch;
		else                      gnt = gnt_none;
	end

	assign load_req_ready  = (gnt == gnt_load);
	assign exec_req_ready  = (gnt == gnt_exec);
	assign fetch_req_ready = (gnt == gnt_fetch);

	////////////////////
	// RAM request mux
	////////////////////

	always_comb begin
		ram_en    = (gnt != gnt_none);
		ram_we    = 1'b0;
		ram_addr  = fetch_req_addr;
		ram_wdata = load_req_wdata;
		case (gnt)
			gnt_load: begin
				ram_we   = 1'b1;
				ram_addr = load_req_addr;
			end
			gnt_exec: begin
				ram_we    = exec_req_we;
				ram_addr  = exec_req_addr;
				// Byte store lands in the low half of the word
				ram_wdata = {{(word_w-data_w){1'b0}}, exec_req_wdata};
			end
			default: ;
		endcase
	end

	// Track read ownership for the response cycle
	always_ff @(posedge g_clk or negedge rst_n) begin
		if (!rst_n)
			rd_gnt <= gnt_none;
		else if (ram_en && !ram_we)
			rd_gnt <= gnt;
		else
			rd_gnt <= gnt_none;
	end

	////////////////////
	// Response routing
	////////////////////

	assign exec_rsp_valid  = (rd_gnt == gnt_exec);
	assign exec_rsp_data   = ram_rdata[data_w-1:0];
	assign fetch_rsp_valid = (rd_gnt == gnt_fetch);
	assign fetch_rsp_data  = ram_rdata;

endmodule

// ==== hdl/unified_ram.sv ====
module unified_ram import acc_pkg::*; (
	input  logic              g_clk,
	input  logic              ram_en,
	input  logic              ram_we,
	input  logic [addr_w-1:0] ram_addr,
	input  logic [word_w-1:0] ram_wdata,
	output logic [word_w-1:0] ram_rdata
);

	localparam int depth = 1 << addr_w;

	// Shared program and data store
	logic [word_w-1:0] mem [0:depth-1];

	////////////////////
	// Single port access
	////////////////////

	// Write or read per enabled cycle, never both
	always_ff @(posedge g_clk) begin
		if (ram_en) begin
			if (ram_we)
				mem[ram_addr] <= ram_wdata;
			else
				// Read data valid one cycle later
				ram_rdata <= mem[ram_addr];
		end
	end

endmodule

// ==== hdl/fetch_stage.sv ====
module fetch_stage import acc_pkg::*; (
	input  logic              g_clk,
	input  logic              rst_n,
	input  logic              run,
	// Memory port
	output logic              fetch_req_valid,
	output logic [addr_w-1:0] fetch_req_addr,
	input  logic              fetch_req_ready,
	input  logic              fetch_rsp_valid,
	input  logic [word_w-1:0] fetch_rsp_data,
	// Instruction port toward execute
	output logic              instr_valid,
	output logic [word_w-1:0] instr_word,
	output logic [addr_w-1:0] instr_pc,
	input  logic              instr_ready,
	// Branch redirect from execute
	input  logic              redirect_valid,
	input  logic [addr_w-1:0] redirect_pc
);

	logic              run_q;
	logic              active;
	// One read in flight at a time
	logic              outstanding;
	// In-flight word belongs to the wrong path
	logic              discard;
	logic              buf_valid;
	logic [word_w-1:0] buf_word;
	logic [addr_w-1:0] buf_pc;
	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] req_pc;
	logic              req_fire;
	logic              drain;

	assign drain    = buf_valid & instr_ready;
	assign req_fire = fetch_req_valid & fetch_req_ready;

	// Next read only if the buffer has room when data returns
	assign fetch_req_valid = active & ~outstanding & (~buf_valid | drain);
	assign fetch_req_addr  = pc;

	assign instr_valid = buf_valid;
	assign instr_word  = buf_word;
	assign instr_pc    = buf_pc;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge g_clk or negedge rst_n) begin
		if (!rst_n) begin
			run_q       <= 1'b0;
			active      <= 1'b0;
			outstanding <= 1'b0;
			discard     <= 1'b0;
			buf_valid   <= 1'b0;
			pc          <= '0;
		end else begin
			run_q <= run;
			if (!run) begin
				// Stopped, memory left to the loader
				active      <= 1'b0;
				outstanding <= 1'b0;
				discard     <= 1'b0;
				buf_valid   <= 1'b0;
			end else if (!run_q) begin
				// Rising edge of run, start at 0
				active <= 1'b1;
				pc     <= '0;
			end else if (redirect_valid) begin
				// Flush the buffer and drop what comes back
				pc          <= redirect_pc;
				buf_valid   <= 1'b0;
				outstanding <= req_fire;
				discard     <= req_fire;
			end else begin
				if (req_fire)
					pc <= pc + 1'b1;
				if (req_fire)
					outstanding <= 1'b1;
				else if (fetch_rsp_valid)
					outstanding <= 1'b0;
				if (fetch_rsp_valid)
					discard <= 1'b0;
				if (fetch_rsp_valid && !discard)
					buf_valid <= 1'b1;
				else if (drain)
					buf_valid <= 1'b0;
			end
		end
	end

	// Buffer payload
	always_ff @(posedge g_clk) begin
		if (req_fire)
			req_pc <= pc;
		if (fetch_rsp_valid) begin
			buf_word <= fetch_rsp_data;
			buf_pc   <= req_pc;
		end
	end

endmodule

// ==== hdl/exec_stage.sv ====
module exec_stage import acc_pkg::*; (
	input  logic              g_clk,
	input  logic              rst_n,
	// Instruction port from fetch
	input  logic              instr_valid,
	input  logic [word_w-1:0] instr_word,
	input  logic [addr_w-1:0] instr_pc,
	output logic              instr_ready,
	// Redirect toward fetch
	output logic              redirect_valid,
	output logic [addr_w-1:0] redirect_pc,
	// Data memory port
	output logic              exec_req_valid,
	output logic [addr_w-1:0] exec_req_addr,
	output logic              exec_req_we,
	output logic [data_w-1:0] exec_req_wdata,
	input  logic              exec_req_ready,
	input  logic              exec_rsp_valid,
	input  logic [data_w-1:0] exec_rsp_data,
	// Input device
	input  logic              in_valid,
	input  logic [data_w-1:0] in_data,
	output logic              in_ready,
	// Output device
	output logic              out_valid,
	output logic [data_w-1:0] out_data,
	input  logic              out_ready,
	// Status
	output logic              halted,
	output logic [data_w-1:0] acc,
	output logic              flag_c,
	output logic              flag_v,
	output logic              flag_z
);

	exec_state_t       state;
	exec_state_t       state_nxt;
	opcode_t           ir_op;
	logic [data_w-1:0] ir_opnd;
	logic [addr_w-1:0] ir_pc;
	logic              take;
	logic              jump_taken;
	logic [data_w-1:0] alu_b;
	logic [data_w-1:0] alu_result;
	logic              alu_c;
	logic              alu_v;
	logic              alu_z;
	logic              acc_we;
	logic              v_we;

	assign instr_ready = (state == ex_idle);
	assign take        = instr_valid & instr_ready;
	assign halted      = (state == ex_halt);
	assign in_ready    = (state == ex_in_wait);
	assign out_valid   = (state == ex_out_wait);

	////////////////////
	// Branch and memory
	////////////////////

	// jz looks at the registered Z only
	assign jump_taken = (ir_op == op_jmp) | ((ir_op == op_jz) & flag_z);
	// Fall-through target is already on the prefetched path
	assign redirect_valid = (state == ex_exec) & jump_taken &
		(ir_opnd[addr_w-1:0] != ir_pc + 1'b1);
	assign redirect_pc = ir_opnd[addr_w-1:0];

	assign exec_req_valid = (state == ex_exec) & ((ir_op == op_ldm) | (ir_op == op_stm));
	assign exec_req_addr  = ir_opnd[addr_w-1:0];
	assign exec_req_we    = (ir_op == op_stm);
	assign exec_req_wdata = acc;

	// Loaded byte goes through the ALU pass path for Z
	always_comb begin
		case (state)
			ex_mem_wait: alu_b = exec_rsp_data;
			ex_in_wait:  alu_b = in_data;
			default:     alu_b = ir_opnd;
		endcase
	end

	alu u_alu (
		.opcode    (ir_op),
		.a         (acc),
		.b         (alu_b),
		.flag_c_in (flag_c),
		.result    (alu_result),
		.c_out     (alu_c),
		.v_out     (alu_v),
		.z_out     (alu_z)
	);

	// Acc writers and V writers
	always_comb begin
		acc_we = 1'b0;
		v_we   = 1'b0;
		case (state)
			ex_exec: begin
				acc_we = ir_op inside {op_ldi, op_add, op_sub, op_and, op_xor, op_shl, op_shr};
				v_we   = ir_op inside {op_add, op_sub, op_shl, op_shr};
			end
			ex_mem_wait: acc_we = exec_rsp_valid;
			ex_in_wait:  acc_we = in_valid;
			default: ;
		endcase
	end

	////////////////////
	// FSM
	////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			ex_idle: if (take) state_nxt = ex_exec;
			ex_exec: begin
				case (ir_op)
					op_halt: state_nxt = ex_halt;
					// Stay until the arbiter accepts
					op_ldm:  if (exec_req_ready) state_nxt = ex_mem_wait;
					op_stm:  if (exec_req_ready) state_nxt = ex_idle;
					op_in:   state_nxt = ex_in_wait;
					op_out:  state_nxt = ex_out_wait;
					default: state_nxt = ex_idle;
				endcase
			end
			ex_mem_wait: if (exec_rsp_valid) state_nxt = ex_idle;
			ex_in_wait:  if (in_valid) state_nxt = ex_idle;
			ex_out_wait: if (out_ready) state_nxt = ex_idle;
			default: ;
		endcase
	end

	always_ff @(posedge g_clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ex_idle;
			acc    <= '0;
			flag_c <= 1'b0;
			flag_v <= 1'b0;
			flag_z <= 1'b0;
		end else begin
			state <= state_nxt;
			// C passes through unchanged for non-arithmetic writes
			if (acc_we) begin
				acc    <= alu_result;
				flag_c <= alu_c;
				flag_z <= alu_z;
			end
			if (v_we)
				flag_v <= alu_v;
		end
	end

	// Instruction register and output byte
	always_ff @(posedge g_clk) begin
		if (take) begin
			ir_op   <= opcode_t'(instr_word[word_w-1 -: opc_w]);
			ir_opnd <= instr_word[data_w-1:0];
			ir_pc   <= instr_pc;
		end
		if (state == ex_exec && ir_op == op_out)
			out_data <= acc;
	end

endmodule

// ==== hdl/acc_processor.sv ====
module acc_processor import acc_pkg::*; (
	input  logic              g_clk,
	input  logic              rst_n,
	input  logic              run,
	// Program loader
	input  logic              prog_valid,
	output logic              prog_ready,
	input  logic [addr_w-1:0] prog_addr,
	input  logic [word_w-1:0] prog_data,
	// Input device
	input  logic              in_valid,
	input  logic [data_w-1:0] in_data,
	output logic              in_ready,
	// Output device
	output logic              out_valid,
	output logic [data_w-1:0] out_data,
	input  logic              out_ready,
	// Status
	output logic              halted,
	output logic [data_w-1:0] acc,
	output logic              flag_c,
	output logic              flag_v,
	output logic              flag_z
);

	////////////////////
	// Interconnect
	////////////////////

	// Execute data port
	logic              exec_req_valid;
	logic [addr_w-1:0] exec_req_addr;
	logic              exec_req_we;
	logic [data_w-1:0] exec_req_wdata;
	logic              exec_req_ready;
	logic              exec_rsp_valid;
	logic [data_w-1:0] exec_rsp_data;
	// Fetch port
	logic              fetch_req_valid;
	logic [addr_w-1:0] fetch_req_addr;
	logic              fetch_req_ready;
	logic              fetch_rsp_valid;
	logic [word_w-1:0] fetch_rsp_data;
	// Stage to stage
	logic              instr_valid;
	logic [word_w-1:0] instr_word;
	logic [addr_w-1:0] instr_pc;
	logic              instr_ready;
	logic              redirect_valid;
	logic [addr_w-1:0] redirect_pc;
	// RAM
	logic              ram_en;
	logic              ram_we;
	logic [addr_w-1:0] ram_addr;
	logic [word_w-1:0] ram_wdata;
	logic [word_w-1:0] ram_rdata;

	// Loader is the top priority requester
	mem_arbiter u_arb (
		.g_clk           (g_clk),
		.rst_n           (rst_n),
		.load_req_valid  (prog_valid),
		.load_req_addr   (prog_addr),
		.load_req_wdata  (prog_data),
		.load_req_ready  (prog_ready),
		.exec_req_valid  (exec_req_valid),
		.exec_req_addr   (exec_req_addr),
		.exec_req_we     (exec_req_we),
		.exec_req_wdata  (exec_req_wdata),
		.exec_req_ready  (exec_req_ready),
		.exec_rsp_valid  (exec_rsp_valid),
		.exec_rsp_data   (exec_rsp_data),
		.fetch_req_valid (fetch_req_valid),
		.fetch_req_addr  (fetch_req_addr),
		.fetch_req_ready (fetch_req_ready),
		.fetch_rsp_valid (fetch_rsp_valid),
		.fetch_rsp_data  (fetch_rsp_data),
		.ram_en          (ram_en),
		.ram_we          (ram_we),
		.ram_addr        (ram_addr),
		.ram_wdata       (ram_wdata),
		.ram_rdata       (ram_rdata)
	);

	unified_ram u_ram (
		.g_clk     (g_clk),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	fetch_stage u_fetch (
		.g_clk           (g_clk),
		.rst_n           (rst_n),
		.run             (run),
		.fetch_req_valid (fetch_req_valid),
		.fetch_req_addr  (fetch_req_addr),
		.fetch_req_ready (fetch_req_ready),
		.fetch_rsp_valid (fetch_rsp_valid),
		.fetch_rsp_data  (fetch_rsp_data),
		.instr_valid     (instr_valid),
		.instr_word      (instr_word),
		.instr_pc        (instr_pc),
		.instr_ready     (instr_ready),
		.redirect_valid  (redirect_valid),
		.redirect_pc     (redirect_pc)
	);

	exec_stage u_exec (
		.g_clk          (g_clk),
		.rst_n          (rst_n),
		.instr_valid    (instr_valid),
		.instr_word     (instr_word),
		.instr_pc       (instr_pc),
		.instr_ready    (instr_ready),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.exec_req_valid (exec_req_valid),
		.exec_req_addr  (exec_req_addr),
		.exec_req_we    (exec_req_we),
		.exec_req_wdata (exec_req_wdata),
		.exec_req_ready (exec_req_ready),
		.exec_rsp_valid (exec_rsp_valid),
		.exec_rsp_data  (exec_rsp_data),
		.in_valid       (in_valid),
		.in_data        (in_data),
		.in_ready       (in_ready),
		.out_valid      (out_valid),
		.out_data       (out_data),
		.out_ready      (out_ready),
		.halted         (halted),
		.acc            (acc),
		.flag_c         (flag_c),
		.flag_v         (flag_v),
		.flag_z         (flag_z)
	);

endmodule

// ==== sim/acc_processor_assertions.sv ====
module acc_processor_assertions import acc_pkg::*; (
	input logic              g_clk,
	input logic              rst_n,
	input logic              out_valid,
	input logic [data_w-1:0] out_data,
	input logic              out_ready,
	input logic              load_req_valid,
	input logic              load_req_ready,
	input logic              exec_req_valid,
	input logic              exec_req_ready,
	input logic              fetch_req_valid,
	input logic              fetch_req_ready,
	input logic              halted
);

	////////////////////
	// Output device
	////////////////////

	// Byte held until the device takes it
	property out_held;
		@(posedge g_clk) disable iff (!rst_n)
			out_valid && !out_ready |=> out_valid && $stable(out_data);
	endproperty

	////////////////////
	// Arbiter and status
	////////////////////

	// Ready goes only to the highest priority valid requester
	// So at most one memory owner per cycle
	property single_grant;
		@(posedge g_clk) disable iff (!rst_n)
			(!load_req_ready || load_req_valid) &&
			(!exec_req_ready || (exec_req_valid && !load_req_valid)) &&
			(!fetch_req_ready || (fetch_req_valid && !load_req_valid && !exec_req_valid));
	endproperty

	// Only reset leaves the halt state
	property halt_sticky;
		@(posedge g_clk) disable iff (!rst_n)
			halted |=> halted;
	endproperty

	out_held_check: assert property (out_held)
		else $error("out_valid dropped or out_data changed before out_ready");
	single_grant_check: assert property (single_grant)
		else $error("arbiter ready given out of priority order or to more than one requester");
	halt_sticky_check: assert property (halt_sticky)
		else $error("halted fell without a reset");

endmodule

bind acc_processor acc_processor_assertions u_assertions (
	.g_clk           (g_clk),
	.rst_n           (rst_n),
	.out_valid       (out_valid),
	.out_data        (out_data),
	.out_ready       (out_ready),
	.load_req_valid  (prog_valid),
	.load_req_ready  (prog_ready),
	.exec_req_valid  (exec_req_valid),
	.exec_req_ready  (exec_req_ready),
	.fetch_req_valid (fetch_req_valid),
	.fetch_req_ready (fetch_req_ready),
	.halted          (halted)
);

// ==== sim/tb_acc_processor.sv ====
module tb_acc_processor import acc_pkg::*; ();

	localparam int num_tests  = 6;
	localparam int halt_limit = 1500;

	logic              g_clk;
	logic              rst_n;
	logic              run;
	logic              prog_valid;
	logic              prog_ready;
	logic [addr_w-1:0] prog_addr;
	logic [word_w-1:0] prog_data;
	logic              in_valid;
	logic [data_w-1:0] in_data;
	logic              in_ready;
	logic              out_valid;
	logic [data_w-1:0] out_data;
	logic              out_ready;
	logic              halted;
	logic [data_w-1:0] acc;
	logic              flag_c;
	logic              flag_v;
	logic              flag_z;

	int    error_count;
	int    test_errors;
	int    tests_run;
	int    failed_tests;
	string test_name;

	// Program image and device traffic
	logic [word_w-1:0] program_q[$];
	logic [data_w-1:0] exp_out[$];
	logic [data_w-1:0] out_seen[$];
	logic [data_w-1:0] in_bytes[$];

	// Instruction set model state
	logic [data_w-1:0] m_acc;
	logic              m_c;
	logic              m_v;
	logic              m_z;
	logic [data_w-1:0] m_mem [0:(1 << addr_w) - 1];

	acc_processor UUT (
		.g_clk      (g_clk),
		.rst_n      (rst_n),
		.run        (run),
		.prog_valid (prog_valid),
		.prog_ready (prog_ready),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_ready  (out_ready),
		.halted     (halted),
		.acc        (acc),
		.flag_c     (flag_c),
		.flag_v     (flag_v),
		.flag_z     (flag_z)
	);

	initial begin
		g_clk = 1'b0;
		forever #50 g_clk = ~g_clk;
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_data(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_bool(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
			test_errors++;
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Signed result outside the byte range
	function automatic logic overflows(input int s);
		return (s > (1 << (data_w - 1)) - 1) || (s < -(1 << (data_w - 1)));
	endfunction

	task automatic model_step(input opcode_t op, input logic [data_w-1:0] b);
		int   sa;
		int   sb;
		int   full;
		logic writes;
		sa     = int'($signed(m_acc));
		sb     = int'($signed(b));
		full   = 0;
		writes = 1'b1;
		case (op)
			op_ldi, op_ldm, op_in: m_acc = b;
			op_add: begin
				full  = int'(m_acc) + int'(b);
				m_c   = (full >= (1 << data_w));
				m_v   = overflows(sa + sb);
				m_acc = full[data_w-1:0];
			end
			op_sub: begin
				// Carry means no borrow
				m_c   = (m_acc >= b);
				m_v   = overflows(sa - sb);
				m_acc = m_acc - b;
			end
			op_and: m_acc = m_acc & b;
			op_xor: m_acc = m_acc ^ b;
			op_shl: begin
				m_c   = m_acc[data_w-1];
				m_v   = 1'b0;
				m_acc = m_acc << 1;
			end
			op_shr: begin
				m_c   = m_acc[0];
				m_v   = 1'b0;
				m_acc = m_acc >> 1;
			end
			default: writes = 1'b0;
		endcase
		// Z follows every acc write
		if (writes)
			m_z = (m_acc == '0);
	endtask

	task automatic put_word(input opcode_t op, input logic [data_w-1:0] opnd);
		program_q.push_back({op, {(word_w - opc_w - data_w){1'b0}}, opnd});
	endtask

	// Straight-line programs only, the model does not follow jumps
	task automatic emit(input opcode_t op, input logic [data_w-1:0] opnd);
		put_word(op, opnd);
		case (op)
			op_stm: m_mem[opnd] = m_acc;
			op_ldm: model_step(op, m_mem[opnd]);
			op_out: exp_out.push_back(m_acc);
			op_in, op_nop, op_halt: ;
			default: model_step(op, opnd);
		endcase
	endtask

	task automatic new_program();
		program_q.delete();
		exp_out.delete();
		out_seen.delete();
		in_bytes.delete();
		m_acc = '0;
		m_c   = 1'b0;
		m_v   = 1'b0;
		m_z   = 1'b0;
	endtask

	////////////////////
	// Sequencing
	////////////////////

	task automatic apply_reset();
		@(posedge g_clk);
		#10;
		rst_n = 1'b0;
		run   = 1'b0;
		repeat (5) @(posedge g_clk);
		#10;
		rst_n = 1'b1;
	endtask

	task automatic load_program();
		int waited;
		foreach (program_q[i]) begin
			prog_valid = 1'b1;
			prog_addr  = addr_w'(i);
			prog_data  = program_q[i];
			waited     = 0;
			@(negedge g_clk);
			while (!prog_ready && waited < 20) begin
				@(negedge g_clk);
				waited++;
			end
			if (!prog_ready) begin
				$display("%s: loader write to %0d was never accepted", test_name, i);
				test_errors++;
			end
			@(posedge g_clk);
			#10;
		end
		prog_valid = 1'b0;
	endtask

	// Load, start at address 0 and wait for the halt
	task automatic execute_program();
		int cycles;
		load_program();
		run    = 1'b1;
		cycles = 0;
		@(negedge g_clk);
		while (!halted && cycles < halt_limit) begin
			@(negedge g_clk);
			cycles++;
		end
		if (!halted) begin
			$display("%s: halted did not rise within %0d cycles", test_name, halt_limit);
			test_errors++;
		end
	endtask

	task automatic compare_final_state();
		check_bool("halted", halted, 1'b1);
		check_data("acc", acc, m_acc);
		check_flag("flag_c", flag_c, m_c);
		check_flag("flag_v", flag_v, m_v);
		check_flag("flag_z", flag_z, m_z);
		if (out_seen.size() != exp_out.size()) begin
			$display("%s: expected %0d output bytes, the device took %0d", test_name,
				exp_out.size(), out_seen.size());
			test_errors++;
		end else begin
			foreach (exp_out[i])
				check_data("out_data", out_seen[i], exp_out[i]);
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic report_test();
		tests_run++;
		error_count += test_errors;
		if (test_errors == 0) begin
			$display("%s: passed", test_name);
		end else begin
			$display("%s: failed with %0d errors", test_name, test_errors);
			failed_tests++;
		end
		apply_reset();
	endtask

	////////////////////
	// Device models
	////////////////////

	// Takes each byte after a random stall
	task automatic output_device();
		int stall;
		forever begin
			@(negedge g_clk);
			if (out_valid === 1'b1) begin
				stall = $urandom_range(0, 5);
				repeat (stall) @(posedge g_clk);
				@(posedge g_clk);
				#10;
				out_ready = 1'b1;
				@(negedge g_clk);
				if (out_valid === 1'b1)
					out_seen.push_back(out_data);
				@(posedge g_clk);
				#10;
				out_ready = 1'b0;
			end
		end
	endtask

	// Supplies queued bytes, delayed at random
	task automatic input_device();
		int stall;
		forever begin
			@(negedge g_clk);
			if (in_ready === 1'b1 && in_bytes.size() > 0) begin
				stall = $urandom_range(0, 6);
				repeat (stall) @(posedge g_clk);
				@(posedge g_clk);
				#10;
				in_valid = 1'b1;
				in_data  = in_bytes.pop_front();
				@(posedge g_clk);
				#10;
				in_valid = 1'b0;
			end
		end
	endtask

	task automatic watchdog();
		repeat (num_tests * 2000) @(posedge g_clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", num_tests * 2000);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic idle_after_reset();
		start_test("idle_after_reset");
		@(negedge g_clk);
		check_bool("exec_req_valid", UUT.exec_req_valid, 1'b0);
		check_bool("fetch_req_valid", UUT.fetch_req_valid, 1'b0);
		check_bool("exec_rsp_valid", UUT.exec_rsp_valid, 1'b0);
		check_bool("fetch_rsp_valid", UUT.fetch_rsp_valid, 1'b0);
		check_bool("instr_valid", UUT.instr_valid, 1'b0);
		check_bool("redirect_valid", UUT.redirect_valid, 1'b0);
		check_bool("out_valid", out_valid, 1'b0);
		check_bool("in_ready", in_ready, 1'b0);
		check_bool("prog_ready", prog_ready, 1'b0);
		check_bool("halted", halted, 1'b0);
		check_data("acc", acc, '0);
		check_flag("flag_c", flag_c, 1'b0);
		check_flag("flag_v", flag_v, 1'b0);
		check_flag("flag_z", flag_z, 1'b0);
		report_test();
	endtask

	task automatic alu_flags();
		logic [data_w-1:0] opnd [0:1][0:4];
		int s;
		start_test("alu_flags");
		// Signed overflow on add and sub, then xor to zero; unsigned wrap to zero
		opnd = '{'{8'h70, 8'h70, 8'h7f, 8'h61, 8'h33},
			'{8'h90, 8'h70, 8'h01, 8'h0f, 8'hf0}};
		for (s = 0; s < 2; s++) begin
			new_program();
			emit(op_ldi, opnd[s][0]);
			emit(op_add, opnd[s][1]);
			emit(op_sub, opnd[s][2]);
			emit(op_xor, opnd[s][3]);
			emit(op_and, opnd[s][4]);
			emit(op_halt, 8'h00);
			execute_program();
			compare_final_state();
			if (s == 0)
				apply_reset();
		end
		report_test();
	endtask

	task automatic memory_round_trip();
		logic [31:0]       rnd;
		logic [data_w-1:0] val;
		start_test("memory_round_trip");
		rnd = $urandom;
		val = rnd[data_w-1:0];
		new_program();
		emit(op_ldi, val);
		emit(op_stm, 8'h80);
		// Clear acc so the load must bring the byte back
		emit(op_ldi, 8'h00);
		emit(op_ldm, 8'h80);
		emit(op_out, 8'h00);
		emit(op_halt, 8'h00);
		execute_program();
		compare_final_state();
		report_test();
	endtask

	task automatic input_echo();
		logic [31:0]       rnd;
		logic [data_w-1:0] val;
		start_test("input_echo");
		rnd = $urandom;
		val = rnd[data_w-1:0];
		new_program();
		in_bytes.push_back(val);
		emit(op_in, 8'h00);
		model_step(op_in, val);
		emit(op_add, 8'h01);
		emit(op_out, 8'h00);
		emit(op_halt, 8'h00);
		execute_program();
		compare_final_state();
		report_test();
	endtask

	task automatic countdown_loop();
		start_test("countdown_loop");
		new_program();
		put_word(op_ldi, 8'd3);
		put_word(op_out, 8'd0);
		put_word(op_sub, 8'd1);
		// Fall-through word is the jmp, wrong path once taken
		put_word(op_jz, 8'd5);
		// Prefetched halt behind this jump must be dropped
		put_word(op_jmp, 8'd1);
		put_word(op_halt, 8'd0);
		// Loop trace from the model
		model_step(op_ldi, 8'd3);
		do begin
			exp_out.push_back(m_acc);
			model_step(op_sub, 8'd1);
		end while (!m_z);
		execute_program();
		compare_final_state();
		report_test();
	endtask

	task automatic shift_chain();
		start_test("shift_chain");
		new_program();
		// Sets V first so the shifts must clear it
		emit(op_ldi, 8'h40);
		emit(op_add, 8'h41);
		emit(op_shl, 8'h00);
		emit(op_out, 8'h00);
		emit(op_shr, 8'h00);
		emit(op_shr, 8'h00);
		emit(op_halt, 8'h00);
		execute_program();
		compare_final_state();
		report_test();
	endtask

	initial begin
		void'($urandom(32'he996));
		rst_n        = 1'b0;
		run          = 1'b0;
		prog_valid   = 1'b0;
		prog_addr    = '0;
		prog_data    = '0;
		in_valid     = 1'b0;
		in_data      = '0;
		out_ready    = 1'b0;
		error_count  = 0;
		test_errors  = 0;
		tests_run    = 0;
		failed_tests = 0;
		fork
			output_device();
			input_device();
			watchdog();
		join_none
		apply_reset();
		idle_after_reset();
		alu_flags();
		memory_round_trip();
		input_echo();
		countdown_loop();
		shift_chain();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, failed_tests,
			error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
hdl/acc_pkg.sv
hdl/alu.sv
hdl/mem_arbiter.sv
hdl/unified_ram.sv
hdl/fetch_stage.sv
hdl/exec_stage.sv
hdl/acc_processor.sv
sim/acc_processor_assertions.sv
sim/tb_acc_processor.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_acc_processor -o tb_acc_processor

result=$(./obj_dir/tb_acc_processor)
echo "$result"

if echo "$result" | grep -q "^TEST RESULT: PASS$"; then
	exit 0
fi
exit 1
